// ==== verilog.f ====
video_copy_pkg.sv
pixel_scan.sv
bus_master.sv
frame_store.sv
copy_sequencer.sv
video_copy_top.sv
tb_bus_model.sv
tb_video_copy.sv

// ==== Bender.yml ====
package:
  name: video_copy

sources:
  - video_copy_pkg.sv
  - pixel_scan.sv
  - bus_master.sv
  - frame_store.sv
  - copy_sequencer.sv
  - video_copy_top.sv
  - target: test
    files:
      - tb_bus_model.sv
      - tb_video_copy.sv

// ==== tb_video_copy.sv ====
`timescale 1ns/1ps

module tb_video_copy
	import video_copy_pkg::*;
();

	// worst pixel takes about 20 cycles
	localparam int pixel_cycles = 32;
	localparam int cycle_limit = 3 * frame_pixels * pixel_cycles + 2000;
	localparam int copy_first = 700;
	localparam int copy_second = 1100;

	logic clk;
	logic reset;
	logic run;
	logic capture;
	bus_req_s bus_req;
	logic bus_ack;
	bus_data_t bus_rdata;
	pixel_report_s report;
	logic capture_done;

	// expected scan and report positions
	coord_t ex;
	coord_t ey;
	coord_t rx;
	coord_t ry;
	logic cap_mode;
	logic done_expected;
	// read acked with the write still to come
	logic pixel_open;
	logic stopped;
	logic run_started;
	int writes_done;
	int cycles = 0;
	bus_req_s prev_req;
	logic prev_ack;
	logic strobe;

	video_copy_top u_dut (
		.clk(clk),
		.reset(reset),
		.run(run),
		.capture(capture),
		.bus_req(bus_req),
		.bus_ack(bus_ack),
		.bus_rdata(bus_rdata),
		.report(report),
		.capture_done(capture_done)
	);

	tb_bus_model u_bus_model (
		.clk(clk),
		.reset(reset),
		.bus_req(bus_req),
		.bus_ack(bus_ack),
		.bus_rdata(bus_rdata)
	);

	always #5 clk = ~clk;

	assign strobe = bus_req.read || bus_req.write;

	////////////////////////////////////////////////////////////
	// reference rules
	////////////////////////////////////////////////////////////

	// 512 bytes per input row
	function automatic bus_addr_t in_addr_of(input coord_t cx, input coord_t cy);
		return video_in_base + bus_addr_t'(int'(cy) * 512 + int'(cx));
	endfunction

	// 1024 bytes per screen row with the frame at 100,50
	function automatic bus_addr_t vga_addr_of(input coord_t cx, input coord_t cy);
		return vga_base + bus_addr_t'((int'(cy) + 50) * 1024 + int'(cx) + 100);
	endfunction

	// same data rule as the bus model
	function automatic pixel_t pixel_of(input coord_t cx, input coord_t cy);
		bus_addr_t a;
		a = in_addr_of(cx, cy);
		return a[7:0] ^ a[15:8];
	endfunction

	function automatic pixel_t grey_of(input pixel_t p);
		return {5'd0, p[7:5]} + {5'd0, p[4:2]} + {6'd0, p[1:0]};
	endfunction

	// {y, x} of the following raster position
	function automatic logic [19:0] raster_next(input coord_t cx, input coord_t cy);
		if (cx != frame_width - 1) begin
			return {cy, cx + 10'd1};
		end
		if (cy != frame_height - 1) begin
			return {cy + 10'd1, 10'd0};
		end
		return '0;
	endfunction

	task automatic value_error(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	////////////////////////////////////////////////////////////
	// checker on pre-edge values
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (reset) begin
			{ex, ey, rx, ry} <= '0;
			cap_mode <= 1'b0;
			done_expected <= 1'b0;
			pixel_open <= 1'b0;
			run_started <= 1'b0;
			writes_done <= 0;
			prev_req <= '0;
			prev_ack <= 1'b0;
		end else begin
			prev_req <= bus_req;
			prev_ack <= bus_ack;
			if (run) begin
				run_started <= 1'b1;
			end
			// quiet after reset
			assert (run_started || !(strobe || report.valid || capture_done))
				else value_error("bus or report activity before run was raised");
			assert (!(bus_req.read && bus_req.write))
				else value_error("read and write high together");
			// held request
			assert (!(prev_req.read || prev_req.write) || prev_ack || bus_req == prev_req)
				else value_error("request changed before ack");
			assert (!strobe || bus_req.byte_en == 4'b0001)
				else value_error($sformatf("byte_en %b", bus_req.byte_en));
			assert (!stopped || !strobe) else value_error("bus request while run is low");
			assert (capture_done == done_expected)
				else value_error($sformatf("capture_done %0b, expected %0b",
					capture_done, done_expected));
			assert (!done_expected || !strobe)
				else value_error("bus request after capture finished");
			// scan restarts at 0,0 after a capture pulse
			if (capture) begin
				{ex, ey, rx, ry} <= '0;
				cap_mode <= 1'b1;
			end
			if (bus_req.read && bus_ack) begin
				assert (!pixel_open) else value_error("second read before the write");
				assert (bus_req.addr == in_addr_of(ex, ey))
					else value_error($sformatf("read addr %h, expected %h at %0d,%0d",
						bus_req.addr, in_addr_of(ex, ey), ex, ey));
				pixel_open <= 1'b1;
			end
			if (bus_req.write && bus_ack) begin
				assert (pixel_open) else value_error("write without a read");
				assert (bus_req.addr == vga_addr_of(ex, ey))
					else value_error($sformatf("write addr %h, expected %h at %0d,%0d",
						bus_req.addr, vga_addr_of(ex, ey), ex, ey));
				assert (bus_req.wdata == bus_data_t'(pixel_of(ex, ey)))
					else value_error($sformatf("write data %h, expected %h",
						bus_req.wdata, pixel_of(ex, ey)));
				// every captured pixel is reported before its write
				assert (!cap_mode || {ry, rx} == raster_next(ex, ey))
					else value_error($sformatf("no report for %0d,%0d before its write",
						ex, ey));
				pixel_open <= 1'b0;
				writes_done <= writes_done + 1;
				{ey, ex} <= raster_next(ex, ey);
				if (cap_mode && ex == frame_width - 1 && ey == frame_height - 1) begin
					cap_mode <= 1'b0;
					done_expected <= 1'b1;
				end
			end
			if (report.valid) begin
				assert (cap_mode) else value_error("report outside capture");
				assert (report.x == rx && report.y == ry)
					else value_error($sformatf("report at %0d,%0d, expected %0d,%0d",
						report.x, report.y, rx, ry));
				assert (report.grey == grey_of(pixel_of(rx, ry)))
					else value_error($sformatf("grey %0d, expected %0d",
						report.grey, grey_of(pixel_of(rx, ry))));
				{ry, rx} <= raster_next(rx, ry);
			end
		end
	end

	// hang guard
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Testbench failed");
			$fatal(1);
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	task automatic wait_writes(input int n);
		while (writes_done < n) begin
			@(posedge clk);
		end
	endtask

	// drop run and wait for the pixel in flight
	task automatic stop_run();
		run <= 1'b0;
		@(posedge clk);
		while (strobe || pixel_open) begin
			@(posedge clk);
		end
		stopped <= 1'b1;
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		run = 1'b0;
		capture = 1'b0;
		stopped = 1'b0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		// idle window with run low
		repeat (20) @(posedge clk);
		run <= 1'b1;
		wait_writes(copy_first);
		stop_run();
		repeat (30) @(posedge clk);
		// resumes at the next raster position
		stopped <= 1'b0;
		run <= 1'b1;
		wait_writes(copy_second);
		stop_run();
		capture <= 1'b1;
		@(posedge clk);
		capture <= 1'b0;
		repeat (4) @(posedge clk);
		stopped <= 1'b0;
		run <= 1'b1;
		while (!capture_done) begin
			@(posedge clk);
		end
		// no more requests once done
		repeat (50) @(posedge clk);
		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== tb_bus_model.sv ====
`timescale 1ns/1ps

module tb_bus_model
	import video_copy_pkg::*;
(
	input logic clk,
	input logic reset,
	input bus_req_s bus_req,
	output logic bus_ack,
	output bus_data_t bus_rdata
);

	logic [31:0] lfsr;
	logic busy;
	logic [1:0] wait_cnt;

	// galois step, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// low address byte xor next byte, upper bits carry junk the DUT must ignore
	assign bus_rdata = {bus_req.addr[31:8], bus_req.addr[7:0] ^ bus_req.addr[15:8]};

	// one ack per request, 0 to 3 extra wait cycles
	always @(posedge clk) begin : ack_gen
		logic [1:0] delay;
		if (reset) begin
			lfsr = 32'h92bf_755c;
			busy <= 1'b0;
			wait_cnt <= '0;
			bus_ack <= 1'b0;
		end else begin
			bus_ack <= 1'b0;
			if (bus_ack) begin
				busy <= 1'b0;
			end else if (busy) begin
				if (wait_cnt == 2'd0) begin
					bus_ack <= 1'b1;
				end else begin
					wait_cnt <= wait_cnt - 2'd1;
				end
			end else if (bus_req.read || bus_req.write) begin
				// two bits, one lfsr step each
				delay[0] = lfsr[0];
				lfsr = lfsr_step(lfsr);
				delay[1] = lfsr[0];
				lfsr = lfsr_step(lfsr);
				busy <= 1'b1;
				wait_cnt <= delay;
			end
		end
	end

endmodule

// ==== video_copy_top.sv ====
`timescale 1ns/1ps

module video_copy_top
	import video_copy_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic run,
	input logic capture,
	output bus_req_s bus_req,
	input logic bus_ack,
	input bus_data_t bus_rdata,
	output pixel_report_s report,
	output logic capture_done
);

	// scan
	coord_t x;
	coord_t y;
	logic frame_last;
	logic tick;
	logic step;
	logic restart;
	// bus command path
	logic cmd_valid;
	bus_cmd_s cmd;
	logic cmd_done;
	pixel_t rd_pixel;
	// frame store port
	logic store_we;
	store_addr_t store_waddr;
	store_addr_t store_raddr;
	pixel_t store_wdata;
	pixel_t store_rdata;

	pixel_scan u_scan (
		.clk(clk),
		.reset(reset),
		.step(step),
		.restart(restart),
		.x(x),
		.y(y),
		.frame_last(frame_last),
		.tick(tick)
	);

	bus_master u_bus (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.cmd_done(cmd_done),
		.rd_pixel(rd_pixel),
		.bus_req(bus_req),
		.bus_ack(bus_ack),
		.bus_rdata(bus_rdata)
	);

	frame_store u_store (
		.clk(clk),
		.we(store_we),
		.waddr(store_waddr),
		.raddr(store_raddr),
		.wdata(store_wdata),
		.rdata(store_rdata)
	);

	copy_sequencer u_seq (
		.clk(clk),
		.reset(reset),
		.run(run),
		.capture(capture),
		.x(x),
		.y(y),
		.frame_last(frame_last),
		.tick(tick),
		.step(step),
		.restart(restart),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.cmd_done(cmd_done),
		.rd_pixel(rd_pixel),
		.store_we(store_we),
		.store_waddr(store_waddr),
		.store_raddr(store_raddr),
		.store_wdata(store_wdata),
		.store_rdata(store_rdata),
		.report(report),
		.capture_done(capture_done)
	);

endmodule

// ==== copy_sequencer.sv ====
`timescale 1ns/1ps

module copy_sequencer
	import video_copy_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic run,
	input logic capture,
	input coord_t x,
	input coord_t y,
	input logic frame_last,
	input logic tick,
	output logic step,
	output logic restart,
	output logic cmd_valid,
	output bus_cmd_s cmd,
	input logic cmd_done,
	input pixel_t rd_pixel,
	output logic store_we,
	output store_addr_t store_waddr,
	output store_addr_t store_raddr,
	output pixel_t store_wdata,
	input pixel_t store_rdata,
	output pixel_report_s report,
	output logic capture_done
);

	copy_state_e state;
	// pulses the write command on entry to st_write
	logic write_issue;
	logic capture_pend;
	logic capture_mode;
	logic start;
	// colour byte of the pixel in flight
	pixel_t pixel_q;
	pixel_t grey;
	bus_addr_t in_addr;
	bus_addr_t vga_addr;
	coord_t vga_x;
	coord_t vga_y;
	store_addr_t store_addr;
	logic report_valid;
	coord_t report_x;
	coord_t report_y;
	pixel_t report_grey;

	////////////////////////////////////////////////////////////
	// address mapping and grey conversion
	////////////////////////////////////////////////////////////

	assign in_addr = video_in_base + bus_addr_t'(x) + (bus_addr_t'(y) << video_in_row_shift);

	// frame shifted on screen
	assign vga_x = x + vga_x_offset;
	assign vga_y = y + vga_y_offset;
	assign vga_addr = vga_base + bus_addr_t'(vga_x) + (bus_addr_t'(vga_y) << vga_row_shift);

	// row times 320 plus column
	assign store_addr = store_addr_t'(y) * store_addr_t'(frame_width) + store_addr_t'(x);

	// red 7:5 + green 4:2 + blue 1:0, at most 17
	assign grey = pixel_t'(pixel_q[7:5]) + pixel_t'(pixel_q[4:2]) + pixel_t'(pixel_q[1:0]);

	////////////////////////////////////////////////////////////
	// handshakes
	////////////////////////////////////////////////////////////

	// held capture request or finished capture blocks a new pixel
	assign start = (state == st_idle) && run && tick && !capture_pend && !capture_done;
	assign restart = (state == st_idle) && capture_pend;
	assign step = (state == st_write) && cmd_done;
	assign cmd_valid = start || write_issue;

	always_comb begin
		if (state == st_idle) begin
			cmd = '{write: 1'b0, addr: in_addr, wdata: '0};
		end else begin
			cmd = '{write: 1'b1, addr: vga_addr, wdata: bus_data_t'(pixel_q)};
		end
	end

	// store port, read follows write by one cycle
	assign store_we = (state == st_store);
	assign store_waddr = store_addr;
	assign store_raddr = store_addr;
	assign store_wdata = grey;

	////////////////////////////////////////////////////////////
	// per-pixel state machine
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			write_issue <= 1'b0;
			capture_pend <= 1'b0;
			capture_mode <= 1'b0;
			capture_done <= 1'b0;
			report_valid <= 1'b0;
		end else begin
			write_issue <= 1'b0;
			report_valid <= 1'b0;
			// remember the request until the next gap between pixels
			if (capture) begin
				capture_pend <= 1'b1;
			end else if (restart) begin
				capture_pend <= 1'b0;
			end
			case (state)
				st_idle: begin
					if (restart) begin
						capture_mode <= 1'b1;
						capture_done <= 1'b0;
					end else if (start) begin
						state <= st_read;
					end
				end
				st_read: begin
					if (cmd_done) begin
						if (capture_mode) begin
							state <= st_store;
						end else begin
							state <= st_write;
							write_issue <= 1'b1;
						end
					end
				end
				st_store: state <= st_readback_addr;
				st_readback_addr: state <= st_readback_wait;
				st_readback_wait: begin
					// ram data is here now
					report_valid <= 1'b1;
					state <= st_report;
				end
				st_report: begin
					state <= st_write;
					write_issue <= 1'b1;
				end
				st_write: begin
					if (cmd_done) begin
						state <= st_idle;
						// last pixel of a capture ends it
						if (capture_mode && frame_last) begin
							capture_mode <= 1'b0;
							capture_done <= 1'b1;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// pixel byte and report payload
	always_ff @(posedge clk) begin
		if (state == st_read && cmd_done) begin
			pixel_q <= rd_pixel;
		end
		if (state == st_readback_wait) begin
			report_x <= x;
			report_y <= y;
			report_grey <= store_rdata;
		end
	end

	assign report = '{valid: report_valid, x: report_x, y: report_y, grey: report_grey};

endmodule

// ==== frame_store.sv ====
`timescale 1ns/1ps

module frame_store
	import video_copy_pkg::*;
(
	input logic clk,
	input logic we,
	input store_addr_t waddr,
	input store_addr_t raddr,
	input pixel_t wdata,
	output pixel_t rdata
);

	// one grey byte per pixel, row major
	pixel_t mem [frame_pixels];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// registered read, old data on same-address collision
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

// ==== bus_master.sv ====
`timescale 1ns/1ps

module bus_master
	import video_copy_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic cmd_valid,
	input bus_cmd_s cmd,
	output logic cmd_done,
	output pixel_t rd_pixel,
	output bus_req_s bus_req,
	input logic bus_ack,
	input bus_data_t bus_rdata
);

	// strobes
	logic req_read;
	logic req_write;
	// held payload
	bus_addr_t req_addr;
	bus_data_t req_wdata;
	logic req_open;
	logic accept;

	assign req_open = req_read || req_write;
	// a new command only lands when nothing is outstanding
	assign accept = cmd_valid && !req_open;

	always_ff @(posedge clk) begin
		if (reset) begin
			req_read <= 1'b0;
			req_write <= 1'b0;
		end else if (req_open && bus_ack) begin
			// drop strobe right after the ack cycle
			req_read <= 1'b0;
			req_write <= 1'b0;
		end else if (accept) begin
			req_read <= !cmd.write;
			req_write <= cmd.write;
		end
	end

	// address and data stay put until ack
	always_ff @(posedge clk) begin
		if (accept) begin
			req_addr <= cmd.addr;
			req_wdata <= cmd.wdata;
		end
	end

	assign bus_req = '{
		read: req_read,
		write: req_write,
		byte_en: byte_lane,
		addr: req_addr,
		wdata: req_wdata
	};

	// done and read byte both valid in the ack cycle
	assign cmd_done = req_open && bus_ack;
	assign rd_pixel = bus_rdata[7:0];

endmodule

// ==== pixel_scan.sv ====
`timescale 1ns/1ps

module pixel_scan
	import video_copy_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic step,
	input logic restart,
	output coord_t x,
	output coord_t y,
	output logic frame_last,
	output logic tick
);

	// free-running pace counter
	logic [3:0] throttle;

	always_ff @(posedge clk) begin
		if (reset) begin
			throttle <= '0;
		end else begin
			throttle <= throttle + 4'd1;
		end
	end

	// start allowed once every throttle_mask+1 cycles
	assign tick = (throttle & throttle_mask) == '0;

	////////////////////////////////////////////////////////////
	// raster position
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset || restart) begin
			x <= '0;
			y <= '0;
		end else if (step) begin
			if (x == frame_width - 10'd1) begin
				// end of row, wrap column
				x <= '0;
				if (y == frame_height - 10'd1) begin
					y <= '0;
				end else begin
					y <= y + 10'd1;
				end
			end else begin
				x <= x + 10'd1;
			end
		end
	end

	// bottom right corner of the frame
	assign frame_last = (x == frame_width - 10'd1) && (y == frame_height - 10'd1);

endmodule

// ==== video_copy_pkg.sv ====
package video_copy_pkg;

	////////////////////////////////////////////////////////////
	// frame geometry and memory map
	////////////////////////////////////////////////////////////

	// active video-input frame
	localparam logic [9:0] frame_width = 10'd320;
	localparam logic [9:0] frame_height = 10'd240;
	// one grey byte per pixel in the frame store
	localparam int frame_pixels = 76800;

	// base addresses on the bus
	localparam logic [31:0] video_in_base = 32'h0800_0000;
	localparam logic [31:0] vga_base = 32'h0000_0000;

	// row pitch as a shift, 512 bytes in, 1024 bytes out
	localparam int video_in_row_shift = 9;
	localparam int vga_row_shift = 10;

	// where the copied frame lands on screen
	localparam logic [9:0] vga_x_offset = 10'd100;
	localparam logic [9:0] vga_y_offset = 10'd50;

	// pixel may only start when these throttle bits are zero
	localparam logic [3:0] throttle_mask = 4'd3;
	// every transfer moves the low byte only
	localparam logic [3:0] byte_lane = 4'b0001;

	////////////////////////////////////////////////////////////
	// types
	////////////////////////////////////////////////////////////

	typedef logic [9:0] coord_t;
	typedef logic [31:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;
	// 3-3-2 colour on the bus, grey in the store
	typedef logic [7:0] pixel_t;
	typedef logic [16:0] store_addr_t;

	// request as seen on the outside bus
	typedef struct packed {
		logic read;
		logic write;
		logic [3:0] byte_en;
		bus_addr_t addr;
		bus_data_t wdata;
	} bus_req_s;

	// command from sequencer to bus master
	typedef struct packed {
		logic write;
		bus_addr_t addr;
		bus_data_t wdata;
	} bus_cmd_s;

	// readback of one captured pixel
	typedef struct packed {
		logic valid;
		coord_t x;
		coord_t y;
		pixel_t grey;
	} pixel_report_s;

	typedef enum logic [2:0] {
		st_idle,
		st_read,
		st_store,
		st_readback_addr,
		st_readback_wait,
		st_report,
		st_write
	} copy_state_e;

endpackage
